// ==== files.f ====
logic/buffer_pkg.sv
logic/bank_memory.sv
logic/capture_bank_router.sv
logic/readout_sequencer.sv
logic/buffer_top.sv
verif/buffer_sva.sv
verif/buffer_tb.sv

// ==== logic/bank_memory.sv ====
/*
 * One sample bank with a synchronous write and a registered read.
 * The read port samples rd_addr_i every cycle, so data shows one cycle later.
 */
`timescale 1ns/1ps

module bank_memory
  import buffer_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  wr_en_i,
  input  logic [ADDR_WIDTH-1:0] wr_addr_i,
  input  logic [DATA_WIDTH-1:0] wr_data_i,
  input  logic [ADDR_WIDTH-1:0] rd_addr_i,
  output logic [DATA_WIDTH-1:0] rd_data_o
);

  logic [DATA_WIDTH-1:0] mem [BUFFER_DEPTH];

  always_ff @(posedge adc_clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read, a write to the same address returns the old word
  always_ff @(posedge adc_clk) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// ==== logic/buffer_pkg.sv ====
/*
 * Shared sizes for the ADC capture buffer.
 * CHANNELS and BUFFER_DEPTH must be powers of two. A banking mode above
 * log2(CHANNELS) is clamped when it is latched at arm.
 */
package buffer_pkg;

  //////////////////////////////////////////////////
  // datapath sizes
  //////////////////////////////////////////////////
  localparam int CHANNELS     = 4;
  localparam int DATA_WIDTH   = 16;
  // kept small so a full capture is short in simulation
  localparam int BUFFER_DEPTH = 16;
  localparam int ADDR_WIDTH   = $clog2(BUFFER_DEPTH);
  // one extra bit, set when the bank holds BUFFER_DEPTH words
  localparam int DEPTH_WIDTH  = ADDR_WIDTH + 1;
  localparam int BANK_WIDTH   = $clog2(CHANNELS);

  // active channels = 2 ** mode
  localparam int MODE_WIDTH   = 2;

  //////////////////////////////////////////////////
  // readout flow control
  //////////////////////////////////////////////////
  localparam int CREDIT_MAX   = 4;
  localparam int CREDIT_WIDTH = $clog2(CREDIT_MAX + 1);

  // capture FSM encoding
  localparam logic [1:0] CAP_IDLE = 2'd0;
  localparam logic [1:0] CAP_RUN  = 2'd1;
  localparam logic [1:0] CAP_DONE = 2'd2;

endpackage

// ==== logic/buffer_top.sv ====
/*
 * ADC capture buffer top level, all logic on adc_clk.
 * readout_data_o is only meaningful while readout_valid_o is high.
 */
`timescale 1ns/1ps

module buffer_top
  import buffer_pkg::*;
(
  input  logic                                  adc_clk,
  input  logic                                  arst_n_i,
  input  logic                                  arm_i,
  input  logic [MODE_WIDTH-1:0]                 banking_mode_i,
  input  logic                                  capture_sw_reset_i,
  input  logic                                  readout_sw_reset_i,
  input  logic                                  readout_start_i,
  input  logic [CHANNELS-1:0][DATA_WIDTH-1:0]   adc_data_i,
  input  logic [CHANNELS-1:0]                   adc_valid_i,
  input  logic                                  readout_credit_i,
  output logic [CHANNELS-1:0][DEPTH_WIDTH-1:0]  write_depth_o,
  output logic                                  write_depth_valid_o,
  output logic [DATA_WIDTH-1:0]                 readout_data_o,
  output logic                                  readout_valid_o
);

  logic [CHANNELS-1:0]                  bank_wr_en;
  logic [CHANNELS-1:0][ADDR_WIDTH-1:0]  bank_wr_addr;
  logic [CHANNELS-1:0][DATA_WIDTH-1:0]  bank_wr_data;
  logic [CHANNELS-1:0][DATA_WIDTH-1:0]  bank_rd_data;
  logic                                 capture_done;
  logic [ADDR_WIDTH-1:0]                rd_addr;
  logic [BANK_WIDTH-1:0]                rd_bank;
  logic                                 rd_issue;
  logic [BANK_WIDTH-1:0]                rd_bank_q;

  capture_bank_router capture_bank_router_inst (
    .adc_clk             (adc_clk),
    .arst_n_i            (arst_n_i),
    .arm_i               (arm_i),
    .capture_sw_reset_i  (capture_sw_reset_i),
    .banking_mode_i      (banking_mode_i),
    .adc_data_i          (adc_data_i),
    .adc_valid_i         (adc_valid_i),
    .bank_wr_en_o        (bank_wr_en),
    .bank_wr_addr_o      (bank_wr_addr),
    .bank_wr_data_o      (bank_wr_data),
    .write_depth_o       (write_depth_o),
    .write_depth_valid_o (write_depth_valid_o),
    .capture_done_o      (capture_done)
  );

  // all banks share the read address
  for (genvar b = 0; b < CHANNELS; b++) begin : g_bank
    bank_memory bank_memory_inst (
      .adc_clk   (adc_clk),
      .wr_en_i   (bank_wr_en[b]),
      .wr_addr_i (bank_wr_addr[b]),
      .wr_data_i (bank_wr_data[b]),
      .rd_addr_i (rd_addr),
      .rd_data_o (bank_rd_data[b])
    );
  end

  readout_sequencer readout_sequencer_inst (
    .adc_clk            (adc_clk),
    .arst_n_i           (arst_n_i),
    .readout_start_i    (readout_start_i),
    .readout_sw_reset_i (readout_sw_reset_i),
    .capture_done_i     (capture_done),
    .readout_credit_i   (readout_credit_i),
    .rd_addr_o          (rd_addr),
    .rd_bank_o          (rd_bank),
    .rd_issue_o         (rd_issue),
    .readout_valid_o    (readout_valid_o)
  );

  // bank select follows the read by one cycle, in step with the RAM output
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_bank_q <= '0;
    end else if (rd_issue) begin
      rd_bank_q <= rd_bank;
    end
  end

  assign readout_data_o = bank_rd_data[rd_bank_q];

endmodule

// ==== logic/capture_bank_router.sv ====
/*
 * Capture control and channel-to-bank routing for the ADC buffer.
 * arm_i and banking_mode_i count only while idle; a finished capture is held
 * until capture_sw_reset_i, which must not be raised during a readout.
 */
`timescale 1ns/1ps

module capture_bank_router
  import buffer_pkg::*;
(
  input  logic                                  adc_clk,
  input  logic                                  arst_n_i,
  input  logic                                  arm_i,
  input  logic                                  capture_sw_reset_i,
  input  logic [MODE_WIDTH-1:0]                 banking_mode_i,
  input  logic [CHANNELS-1:0][DATA_WIDTH-1:0]   adc_data_i,
  input  logic [CHANNELS-1:0]                   adc_valid_i,
  output logic [CHANNELS-1:0]                   bank_wr_en_o,
  output logic [CHANNELS-1:0][ADDR_WIDTH-1:0]   bank_wr_addr_o,
  output logic [CHANNELS-1:0][DATA_WIDTH-1:0]   bank_wr_data_o,
  output logic [CHANNELS-1:0][DEPTH_WIDTH-1:0]  write_depth_o,
  output logic                                  write_depth_valid_o,
  output logic                                  capture_done_o
);

  logic [1:0]                           state_q;
  logic [MODE_WIDTH-1:0]                mode_q;
  logic [BANK_WIDTH-1:0]                chan_mask;
  logic [CHANNELS-1:0][BANK_WIDTH-1:0]  cur_bank_q;
  logic [CHANNELS-1:0][DEPTH_WIDTH-1:0] depth_q;
  logic [CHANNELS-1:0]                  ch_wr;
  logic [CHANNELS-1:0]                  ch_bank_end;
  logic [CHANNELS-1:0]                  ch_last_bank;
  logic                                 capture_end;
  logic                                 depth_valid_q;

  // active count minus one, also the bank-to-owner mask
  assign chan_mask = BANK_WIDTH'((1 << mode_q) - 1);

  //////////////////////////////////////////////////
  // per-channel write state
  //////////////////////////////////////////////////
  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      ch_wr[c]        = (state_q == CAP_RUN) && adc_valid_i[c] && (c <= int'(chan_mask));
      // this write lands on the last address of the channel's bank
      ch_bank_end[c]  = (depth_q[cur_bank_q[c]] == DEPTH_WIDTH'(BUFFER_DEPTH - 1));
      ch_last_bank[c] = (int'(cur_bank_q[c]) + int'(chan_mask) + 1 >= CHANNELS);
    end
  end

  // first channel to fill its final bank ends the capture for all
  assign capture_end = |(ch_wr & ch_bank_end & ch_last_bank);

  //////////////////////////////////////////////////
  // bank write ports
  //////////////////////////////////////////////////
  always_comb begin
    for (int b = 0; b < CHANNELS; b++) begin
      bank_wr_en_o[b] = 1'b0;
      for (int c = 0; c < CHANNELS; c++) begin
        if (ch_wr[c] && (cur_bank_q[c] == BANK_WIDTH'(b))) begin
          bank_wr_en_o[b] = 1'b1;
        end
      end
      bank_wr_addr_o[b] = depth_q[b][ADDR_WIDTH-1:0];
      // owner of bank b is b modulo the active count
      bank_wr_data_o[b] = adc_data_i[BANK_WIDTH'(b) & chan_mask];
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= CAP_IDLE;
      mode_q        <= '0;
      cur_bank_q    <= '0;
      depth_q       <= '0;
      depth_valid_q <= 1'b0;
    end else begin
      depth_valid_q <= 1'b0;
      if (capture_sw_reset_i) begin
        state_q <= CAP_IDLE;
        depth_q <= '0;
      end else begin
        case (state_q)
          CAP_IDLE: begin
            if (arm_i) begin
              state_q <= CAP_RUN;
              depth_q <= '0;
              if (banking_mode_i > MODE_WIDTH'(BANK_WIDTH)) begin
                mode_q <= MODE_WIDTH'(BANK_WIDTH);
              end else begin
                mode_q <= banking_mode_i;
              end
              // each channel starts in the bank with its own index
              for (int c = 0; c < CHANNELS; c++) begin
                cur_bank_q[c] <= BANK_WIDTH'(c);
              end
            end
          end
          CAP_RUN: begin
            for (int b = 0; b < CHANNELS; b++) begin
              if (bank_wr_en_o[b]) begin
                depth_q[b] <= depth_q[b] + 1'b1;
              end
            end
            // step to the next owned bank, one active count further on
            for (int c = 0; c < CHANNELS; c++) begin
              if (ch_wr[c] && ch_bank_end[c] && !ch_last_bank[c]) begin
                cur_bank_q[c] <= cur_bank_q[c] + chan_mask + 1'b1;
              end
            end
            if (capture_end) begin
              state_q       <= CAP_DONE;
              depth_valid_q <= 1'b1;
            end
          end
          default: begin
            // done, held until a capture reset
            state_q <= state_q;
          end
        endcase
      end
    end
  end

  assign write_depth_o       = depth_q;
  assign write_depth_valid_o = depth_valid_q;
  assign capture_done_o      = (state_q == CAP_DONE);

endmodule

// ==== logic/readout_sequencer.sv ====
/*
 * Walks every bank in order under credit-based flow control.
 * Start is ignored without capture_done_i or while a readout runs;
 * readout_sw_reset_i drops the in-flight word and refills the credits.
 */
`timescale 1ns/1ps

module readout_sequencer
  import buffer_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  input  logic                  readout_start_i,
  input  logic                  readout_sw_reset_i,
  input  logic                  capture_done_i,
  input  logic                  readout_credit_i,
  output logic [ADDR_WIDTH-1:0] rd_addr_o,
  output logic [BANK_WIDTH-1:0] rd_bank_o,
  output logic                  rd_issue_o,
  output logic                  readout_valid_o
);

  logic                               running_q;
  logic [CREDIT_WIDTH-1:0]            credits_q;
  logic [CREDIT_WIDTH-1:0]            credits_next;
  // bank index on top, address below, so one counter covers the walk
  logic [BANK_WIDTH+ADDR_WIDTH-1:0]   walk_q;
  logic                               issue;
  logic                               valid_q;

  // a read goes out only while a credit is held
  assign issue = running_q && (credits_q != '0) && !readout_sw_reset_i;

  //////////////////////////////////////////////////
  // credit counter
  //////////////////////////////////////////////////
  always_comb begin
    credits_next = credits_q;
    if (issue) begin
      credits_next = credits_next - 1'b1;
    end
    // saturate at the consumer's buffer size
    if (readout_credit_i && (credits_next != CREDIT_WIDTH'(CREDIT_MAX))) begin
      credits_next = credits_next + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // address walk and valid pipeline
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      running_q <= 1'b0;
      credits_q <= CREDIT_WIDTH'(CREDIT_MAX);
      walk_q    <= '0;
      valid_q   <= 1'b0;
    end else if (readout_sw_reset_i) begin
      running_q <= 1'b0;
      credits_q <= CREDIT_WIDTH'(CREDIT_MAX);
      walk_q    <= '0;
      valid_q   <= 1'b0;
    end else begin
      // valid trails the issue by the bank read latency
      valid_q   <= issue;
      credits_q <= credits_next;
      if (!running_q) begin
        if (readout_start_i && capture_done_i) begin
          running_q <= 1'b1;
          walk_q    <= '0;
        end
      end else if (issue) begin
        walk_q <= walk_q + 1'b1;
        // last address of the last bank
        if (&walk_q) begin
          running_q <= 1'b0;
        end
      end
    end
  end

  assign rd_addr_o       = walk_q[ADDR_WIDTH-1:0];
  assign rd_bank_o       = walk_q[BANK_WIDTH+ADDR_WIDTH-1:ADDR_WIDTH];
  assign rd_issue_o      = issue;
  assign readout_valid_o = valid_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the capture buffer testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module buffer_tb -f files.f \
  -o buffer_sim || { echo "build error"; exit 1; }
out=$(./obj_dir/buffer_sim)
echo "$out"
echo "$out" | grep -q "All checks passed" && exit 0 || exit 1

// ==== verif/buffer_sva.sv ====
/*
 * Protocol assertions bound onto buffer_top, top-level ports only.
 * Assumes the consumer starts with CREDIT_MAX credits after either reset.
 */
`timescale 1ns/1ps

module buffer_sva
  import buffer_pkg::*;
(
  input logic adc_clk,
  input logic arst_n_i,
  input logic readout_sw_reset_i,
  input logic readout_credit_i,
  input logic readout_valid_o,
  input logic write_depth_valid_o
);

  // words delivered to the consumer and not yet paid back
  int outstanding_q;

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= 0;
    end else if (readout_sw_reset_i) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(readout_valid_o) - int'(readout_credit_i);
    end
  end

  credit_held_a : assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    readout_valid_o |-> (outstanding_q < CREDIT_MAX))
    else $error("readout word delivered while the consumer had no credit left");

  depth_pulse_a : assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    write_depth_valid_o |=> !write_depth_valid_o)
    else $error("write depth valid held longer than one cycle");

  reset_quiet_a : assert property (@(posedge adc_clk)
    !arst_n_i |-> (!readout_valid_o && !write_depth_valid_o))
    else $error("valid output high during reset");

endmodule

bind buffer_top buffer_sva buffer_sva_inst (.*);

// ==== verif/buffer_tb.sv ====
/*
 * Testbench for buffer_top with a sample model and a credit-returning consumer.
 * Readout words are compared only below the reported depth of their bank.
 */
`timescale 1ns/1ps

module buffer_tb
  import buffer_pkg::*;
();

  logic                                 adc_clk;
  logic                                 arst_n_i;
  logic                                 arm_i;
  logic [MODE_WIDTH-1:0]                banking_mode_i;
  logic                                 capture_sw_reset_i;
  logic                                 readout_sw_reset_i;
  logic                                 readout_start_i;
  logic [CHANNELS-1:0][DATA_WIDTH-1:0]  adc_data_i;
  logic [CHANNELS-1:0]                  adc_valid_i;
  logic                                 readout_credit_i;
  logic [CHANNELS-1:0][DEPTH_WIDTH-1:0] write_depth_o;
  logic                                 write_depth_valid_o;
  logic [DATA_WIDTH-1:0]                readout_data_o;
  logic                                 readout_valid_o;

  int seed = 87986;
  int active;
  int test_errs;
  int passed;
  int failed;
  // samples the DUT accepted per channel, in capture order
  logic [DATA_WIDTH-1:0] accepted [CHANNELS][CHANNELS*BUFFER_DEPTH];
  int                    accepted_cnt [CHANNELS];
  logic [DATA_WIDTH-1:0] sample_ctr [CHANNELS];

  buffer_top buffer_top_inst (.*);

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("error: %s", what);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: FAILED with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // random valid mask, each channel shows its own running count
  task automatic present_samples();
    logic [CHANNELS-1:0] mask;
    mask = CHANNELS'($random(seed));
    for (int c = 0; c < CHANNELS; c++) begin
      adc_data_i[c] <= sample_ctr[c];
      if (mask[c]) begin
        sample_ctr[c] = sample_ctr[c] + 1'b1;
      end
    end
    adc_valid_i <= mask;
  endtask

  // words in bank b, from the owner's sample count and the bank's place in its chain
  function automatic int bank_depth(input int b);
    int n;
    n = accepted_cnt[b % active] - (b / active) * BUFFER_DEPTH;
    if (n < 0) begin
      n = 0;
    end
    if (n > BUFFER_DEPTH) begin
      n = BUFFER_DEPTH;
    end
    return n;
  endfunction

  task automatic run_capture(input int mode);
    int  chain;
    int  cycles;
    bit  done;
    active = 1 << mode;
    chain  = (CHANNELS / active) * BUFFER_DEPTH;
    for (int c = 0; c < CHANNELS; c++) begin
      accepted_cnt[c] = 0;
    end
    arm_i          <= 1'b1;
    banking_mode_i <= MODE_WIDTH'(mode);
    @(posedge adc_clk);
    arm_i <= 1'b0;
    present_samples();
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < 1000) begin
      @(posedge adc_clk);
      cycles++;
      for (int c = 0; c < active; c++) begin
        if (adc_valid_i[c]) begin
          accepted[c][accepted_cnt[c]] = adc_data_i[c];
          accepted_cnt[c]++;
          // first channel to fill its chain ends the capture
          if (accepted_cnt[c] == chain) begin
            done = 1'b1;
          end
        end
      end
      if (done) begin
        adc_valid_i <= '0;
      end else begin
        present_samples();
      end
    end
    check_true(done, "capture did not fill a channel chain before the timeout");
  endtask

  task automatic check_depth_report();
    int pulses;
    int last_seen;
    pulses    = 0;
    last_seen = -1;
    for (int cyc = 0; cyc < 40; cyc++) begin
      @(posedge adc_clk);
      if (write_depth_valid_o) begin
        pulses++;
        last_seen = cyc;
        for (int b = 0; b < CHANNELS; b++) begin
          check_value($sformatf("write_depth_o[%0d]", b), 32'(write_depth_o[b]),
                      32'(bank_depth(b)));
        end
      end
      // a few quiet cycles after the pulse show it did not repeat
      if (last_seen >= 0 && cyc >= last_seen + 4) begin
        break;
      end
    end
    check_true(pulses == 1, $sformatf("expected one write depth pulse, saw %0d", pulses));
  endtask

  // a negative stop_after reads everything, otherwise abort after that many words
  task automatic run_readout(input int stop_after);
    int received;
    int owed;
    int cycles;
    int target;
    int b;
    int a;
    received = 0;
    owed     = 0;
    cycles   = 0;
    target   = (stop_after < 0) ? CHANNELS * BUFFER_DEPTH : stop_after;
    readout_start_i <= 1'b1;
    @(posedge adc_clk);
    readout_start_i <= 1'b0;
    while (received < target && cycles < 2000) begin
      @(posedge adc_clk);
      cycles++;
      if (readout_valid_o) begin
        b = received / BUFFER_DEPTH;
        a = received % BUFFER_DEPTH;
        if (a < bank_depth(b)) begin
          check_value($sformatf("readout_data_o bank %0d addr %0d", b, a), 32'(readout_data_o),
                      32'(accepted[b % active][(b / active) * BUFFER_DEPTH + a]));
        end
        received++;
        owed++;
        check_true(owed <= CREDIT_MAX, "consumer holds more words than its credit limit");
      end
      // the consumer frees a slot on a coin toss
      if (owed > 0 && ($random(seed) & 32'h1) != 0) begin
        readout_credit_i <= 1'b1;
        owed--;
      end else begin
        readout_credit_i <= 1'b0;
      end
    end
    check_true(received == target, $sformatf("readout timed out after %0d words", received));
    if (stop_after >= 0) begin
      readout_credit_i   <= 1'b0;
      readout_sw_reset_i <= 1'b1;
      @(posedge adc_clk);
      readout_sw_reset_i <= 1'b0;
      owed = 0;
    end
    // return the remaining credits and watch for stray words
    for (int cyc = 0; cyc < 2 * CREDIT_MAX + 4; cyc++) begin
      @(posedge adc_clk);
      check_true(!readout_valid_o, "readout word after the readout ended");
      if (owed > 0) begin
        readout_credit_i <= 1'b1;
        owed--;
      end else begin
        readout_credit_i <= 1'b0;
      end
    end
  endtask

  task automatic reset_capture();
    capture_sw_reset_i <= 1'b1;
    @(posedge adc_clk);
    capture_sw_reset_i <= 1'b0;
    @(posedge adc_clk);
  endtask

  initial begin
    arst_n_i           = 1'b0;
    arm_i              = 1'b0;
    banking_mode_i     = '0;
    capture_sw_reset_i = 1'b0;
    readout_sw_reset_i = 1'b0;
    readout_start_i    = 1'b0;
    adc_data_i         = '0;
    adc_valid_i        = '0;
    readout_credit_i   = 1'b0;
    test_errs          = 0;
    passed             = 0;
    failed             = 0;
    active             = 1;
    for (int c = 0; c < CHANNELS; c++) begin
      sample_ctr[c]   = DATA_WIDTH'(c * 16'h4000);
      accepted_cnt[c] = 0;
    end
    repeat (10) @(posedge adc_clk);
    arst_n_i <= 1'b1;
    @(posedge adc_clk);

    readout_start_i <= 1'b1;
    @(posedge adc_clk);
    readout_start_i <= 1'b0;
    for (int cyc = 0; cyc < 20; cyc++) begin
      @(posedge adc_clk);
      check_true(!readout_valid_o, "readout ran without a finished capture");
    end
    finish_test("start without capture");

    run_capture(0);
    check_depth_report();
    finish_test("mode 0 capture");

    run_readout(-1);
    finish_test("credit readout");

    run_readout(10);
    run_readout(-1);
    finish_test("readout reset and restart");

    reset_capture();
    run_capture(1);
    check_depth_report();
    run_readout(-1);
    reset_capture();
    run_capture(2);
    check_depth_report();
    run_readout(-1);
    finish_test("mode 1 and mode 2 captures");

    reset_capture();
    run_capture(0);
    check_depth_report();
    run_readout(-1);
    finish_test("capture reset and re-arm");

    $display("%0d tests passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
